// ==== rtl/rom_load_settings.svh ====
`ifndef ROM_LOAD_SETTINGS_SVH
`define ROM_LOAD_SETTINGS_SVH

// Programming bus word address width
`define ROM_LOAD_PW 24

// Host byte address width
`define ROM_LOAD_IOW 25

// Character ROM read address width
`define ROM_LOAD_CHR_AW 10

// Program ROM read address width
`define ROM_LOAD_PRG_AW 10

// Word offsets of the ROM windows on the programming bus
`define ROM_LOAD_CHR_OFFSET 0
`define ROM_LOAD_PRG_OFFSET 'h200

`endif

// ==== rtl/rom_load_pkg.sv ====
`include "rom_load_settings.svh"

package rom_load_pkg;

    // Host side byte address
    typedef logic [`ROM_LOAD_IOW-1:0] ioctl_addr_t;

    // Word address on the programming bus
    typedef logic [`ROM_LOAD_PW-1:0] prog_addr_t;

    // Active low byte lanes
    // Bit 0 low selects the low byte and bit 1 low the high byte
    typedef logic [1:0] prog_mask_t;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;

    // Read addresses of the two ROMs
    typedef logic [`ROM_LOAD_CHR_AW-1:0] chr_addr_t;
    typedef logic [`ROM_LOAD_PRG_AW-1:0] prg_addr_t;

    // Download sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DONE
    } dwnld_state_t;

endpackage

// ==== rtl/rpwp_ram.sv ====
`timescale 1ns/1ps

// One read port and one write port on a shared clock
module rpwp_ram #(
    parameter int DW = 8,
    parameter int AW = 10
) (
    input  logic          clk,

    // Read side
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] dout,

    // Write side
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] din,
    input  logic          we
);

    // Storage array, maps onto block RAM
    logic [DW-1:0] mem [0:(2**AW)-1];

    // Registered read
    // A write to the same address in this cycle is not seen yet
    always_ff @(posedge clk) begin
        dout <= mem[rd_addr];
    end

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

endmodule

// ==== rtl/bram_rom.sv ====
`timescale 1ns/1ps

// Block RAM ROM loaded from the byte wide programming bus
// Each instance only takes the bytes that fall inside its own word window
module bram_rom #(
    parameter int          DW     = 8,
    parameter int          AW     = 10,
    parameter int unsigned OFFSET = 0
) (
    input  logic                     clk,

    // Read port for the core, one cycle latency
    input  logic [AW-1:0]            addr,
    output logic [DW-1:0]            data,

    // Programming bus driven by the download adapter
    input  rom_load_pkg::prog_addr_t prog_addr,
    input  rom_load_pkg::prog_mask_t prog_mask,
    input  rom_load_pkg::byte_t      prog_data,
    input  logic                     prog_we
);

    // An 8 bit ROM packs two bytes per bus word
    // so its window is half as many words as entries
    localparam int unsigned WIN_AW = (DW == 8) ? AW - 1 : AW;

    // Window bounds kept wide so the top end never wraps
    localparam longint unsigned WIN_LO = OFFSET;
    localparam longint unsigned WIN_HI = WIN_LO + (64'd1 << WIN_AW);

    logic                     in_range;
    rom_load_pkg::prog_addr_t prog_aeff;

    // Window decode
    assign in_range = (prog_addr >= WIN_LO) && (prog_addr < WIN_HI);

    // Word address relative to the start of the window
    assign prog_aeff = prog_addr - rom_load_pkg::prog_addr_t'(WIN_LO);

    generate
        if (DW == 8) begin : g_byte
            logic [AW-1:0] wr_addr;
            logic          we;

            // Byte lane becomes the index LSB
            // even bytes have mask bit 0 low
            assign wr_addr = {prog_aeff[AW-2:0], prog_mask[0]};
            assign we      = prog_we && in_range;

            rpwp_ram #(
                .DW(8),
                .AW(AW)
            ) u_ram (
                .clk    (clk),
                .rd_addr(addr),
                .dout   (data),
                .wr_addr(wr_addr),
                .din    (prog_data),
                .we     (we)
            );
        end else if (DW == 16) begin : g_word
            // Lane 0 is the low half and lane 1 the high half
            for (genvar i = 0; i < 2; i++) begin : g_lane
                logic we;

                // Only the lane selected by the active low mask bit
                assign we = prog_we && in_range && !prog_mask[i];

                rpwp_ram #(
                    .DW(8),
                    .AW(AW)
                ) u_ram (
                    .clk    (clk),
                    .rd_addr(addr),
                    .dout   (data[8*i +: 8]),
                    .wr_addr(prog_aeff[AW-1:0]),
                    .din    (prog_data),
                    .we     (we)
                );
            end
        end
    endgenerate

    // Only the two data widths above are built
    a_dw_legal: assert property (@(posedge clk) (DW == 8) || (DW == 16))
        else $error("bram_rom: DW must be 8 or 16");

    // The adapter must select exactly one byte lane per strobe
    a_mask_one_lane: assert property (
        @(posedge clk) prog_we |-> (prog_mask == 2'b10) || (prog_mask == 2'b01)
    ) else $error("bram_rom: bad prog_mask %b on strobe", prog_mask);

endmodule

// ==== rtl/prog_dwnld.sv ====
`timescale 1ns/1ps

// Download adapter
// Converts the host byte stream into a registered word programming bus
module prog_dwnld (
    input  logic                      clk,
    input  logic                      reset,

    // Host stream
    input  logic                      ioctl_download,
    input  logic                      ioctl_wr,
    input  rom_load_pkg::ioctl_addr_t ioctl_addr,
    input  rom_load_pkg::byte_t       ioctl_dout,

    // Programming bus to the ROMs
    output rom_load_pkg::prog_addr_t  prog_addr,
    output rom_load_pkg::prog_mask_t  prog_mask,
    output rom_load_pkg::byte_t       prog_data,
    output logic                      prog_we,

    // Status levels
    output logic                      downloading,
    output logic                      dwnld_done
);

    rom_load_pkg::dwnld_state_t state;
    rom_load_pkg::dwnld_state_t state_nxt;
    logic                       accept;

    // Next state
    // A rise of the download level enters LOAD and a fall leaves it
    always_comb begin
        state_nxt = state;
        case (state)
            rom_load_pkg::IDLE: begin
                if (ioctl_download) begin
                    state_nxt = rom_load_pkg::LOAD;
                end
            end
            rom_load_pkg::LOAD: begin
                if (!ioctl_download) begin
                    state_nxt = rom_load_pkg::DONE;
                end
            end
            rom_load_pkg::DONE: begin
                // A second download restarts loading
                if (ioctl_download) begin
                    state_nxt = rom_load_pkg::LOAD;
                end
            end
            default: begin
                state_nxt = rom_load_pkg::IDLE;
            end
        endcase
    end

    // State register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rom_load_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Strobes count whenever the download level is high
    // including the cycle of the rise, so the first byte is not lost to the state lag
    assign accept = ioctl_wr && ioctl_download;

    // Write strobe lasts exactly one cycle per accepted byte
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= accept;
        end
    end

    // Bus payload, captured with each accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            // Word address is the byte address without its LSB
            prog_addr <= rom_load_pkg::prog_addr_t'(ioctl_addr >> 1);
            // Odd byte enables the high lane and even byte the low lane
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_data <= ioctl_dout;
        end
    end

    // Status straight from the state register
    assign downloading = (state == rom_load_pkg::LOAD);
    assign dwnld_done  = (state == rom_load_pkg::DONE);

    // The bus is only driven while loading
    a_we_in_load: assert property (
        @(posedge clk) disable iff (reset) prog_we |-> (state == rom_load_pkg::LOAD)
    ) else $error("prog_dwnld: prog_we outside LOAD");

endmodule

// ==== rtl/rom_load_top.sv ====
`timescale 1ns/1ps

`include "rom_load_settings.svh"

// ROM loading subsystem
// One download adapter feeding a character ROM and a program ROM
module rom_load_top (
    input  logic                      clk,
    input  logic                      reset,

    // Host download stream
    input  logic                      ioctl_download,
    input  logic                      ioctl_wr,
    input  rom_load_pkg::ioctl_addr_t ioctl_addr,
    input  rom_load_pkg::byte_t       ioctl_dout,

    // Character ROM read port
    input  rom_load_pkg::chr_addr_t   chr_addr,
    output rom_load_pkg::byte_t       chr_data,

    // Program ROM read port
    input  rom_load_pkg::prg_addr_t   prg_addr,
    output rom_load_pkg::word_t       prg_data,

    // Download status
    output logic                      downloading,
    output logic                      dwnld_done
);

    // Shared programming bus, the ROMs only listen
    rom_load_pkg::prog_addr_t prog_addr;
    rom_load_pkg::prog_mask_t prog_mask;
    rom_load_pkg::byte_t      prog_data;
    logic                     prog_we;

    prog_dwnld u_dwnld (
        .clk           (clk),
        .reset         (reset),
        .ioctl_download(ioctl_download),
        .ioctl_wr      (ioctl_wr),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .prog_addr     (prog_addr),
        .prog_mask     (prog_mask),
        .prog_data     (prog_data),
        .prog_we       (prog_we),
        .downloading   (downloading),
        .dwnld_done    (dwnld_done)
    );

    // Character ROM, byte wide
    bram_rom #(
        .DW    (8),
        .AW    (`ROM_LOAD_CHR_AW),
        .OFFSET(`ROM_LOAD_CHR_OFFSET)
    ) u_chr (
        .clk      (clk),
        .addr     (chr_addr),
        .data     (chr_data),
        .prog_addr(prog_addr),
        .prog_mask(prog_mask),
        .prog_data(prog_data),
        .prog_we  (prog_we)
    );

    // Program ROM, word wide
    bram_rom #(
        .DW    (16),
        .AW    (`ROM_LOAD_PRG_AW),
        .OFFSET(`ROM_LOAD_PRG_OFFSET)
    ) u_prg (
        .clk      (clk),
        .addr     (prg_addr),
        .data     (prg_data),
        .prog_addr(prog_addr),
        .prog_mask(prog_mask),
        .prog_data(prog_data),
        .prog_we  (prog_we)
    );

endmodule

// ==== verif/rom_load_tb.sv ====
`timescale 1ns/1ps

`include "rom_load_settings.svh"

module rom_load_tb;

    localparam int CLK_PERIOD = 20;

    // Step kinds in the stimulus table
    localparam int OP_IDLE    = 0;
    localparam int OP_WR      = 1;
    localparam int OP_RD_CHR  = 2;
    localparam int OP_RD_PRG  = 3;
    localparam int OP_STATUS  = 4;

    // Window sizes in bus words, from the ROM geometry
    localparam int CHR_OFF   = `ROM_LOAD_CHR_OFFSET;
    localparam int PRG_OFF   = `ROM_LOAD_PRG_OFFSET;
    localparam int CHR_WORDS = 1 << (`ROM_LOAD_CHR_AW - 1);
    localparam int PRG_WORDS = 1 << `ROM_LOAD_PRG_AW;

    logic                      clk;
    logic                      reset;
    logic                      ioctl_download;
    logic                      ioctl_wr;
    rom_load_pkg::ioctl_addr_t ioctl_addr;
    rom_load_pkg::byte_t       ioctl_dout;
    rom_load_pkg::chr_addr_t   chr_addr;
    rom_load_pkg::byte_t       chr_data;
    rom_load_pkg::prg_addr_t   prg_addr;
    rom_load_pkg::word_t       prg_data;
    logic                      downloading;
    logic                      dwnld_done;

    // Stimulus table, one entry per clock step
    int                        step_op[$];
    rom_load_pkg::ioctl_addr_t step_addr[$];
    rom_load_pkg::byte_t       step_data[$];
    logic                      step_dl[$];
    rom_load_pkg::word_t       step_exp[$];
    string                     step_name[$];

    // Reference images of both ROMs
    rom_load_pkg::byte_t       chr_model [0:(1 << `ROM_LOAD_CHR_AW) - 1];
    rom_load_pkg::word_t       prg_model [0:(1 << `ROM_LOAD_PRG_AW) - 1];

    logic [15:0]               lfsr_state;
    logic                      cur_dl;
    logic                      table_ready;

    // Read issued one step earlier, checked one cycle later
    int                        pending_op;
    rom_load_pkg::word_t       pending_exp;
    string                     pending_name;

    rom_load_top i_rom_load_top (
        .clk           (clk),
        .reset         (reset),
        .ioctl_download(ioctl_download),
        .ioctl_wr      (ioctl_wr),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .chr_addr      (chr_addr),
        .chr_data      (chr_data),
        .prg_addr      (prg_addr),
        .prg_data      (prg_data),
        .downloading   (downloading),
        .dwnld_done    (dwnld_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input rom_load_pkg::byte_t expected,
                              input rom_load_pkg::byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected 0x%02h, actual 0x%02h",
                                name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input rom_load_pkg::word_t expected,
                              input rom_load_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected 0x%04h, actual 0x%04h",
                                name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit taken
    task automatic random_byte(output rom_load_pkg::byte_t b);
        b = 8'h00;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // Window and placement rules applied to one host byte
    task automatic model_write(input int unsigned addr, input rom_load_pkg::byte_t data);
        int unsigned w;
        w = addr >> 1;
        if (w >= CHR_OFF && w < CHR_OFF + CHR_WORDS) begin
            chr_model[addr - 2 * CHR_OFF] = data;
        end
        if (w >= PRG_OFF && w < PRG_OFF + PRG_WORDS) begin
            // Odd byte is the high half
            if (addr[0]) begin
                prg_model[w - PRG_OFF][15:8] = data;
            end else begin
                prg_model[w - PRG_OFF][7:0] = data;
            end
        end
    endtask

    task automatic add_step(input int op, input int unsigned addr,
                            input rom_load_pkg::byte_t data, input rom_load_pkg::word_t exp,
                            input string name);
        step_op.push_back(op);
        step_addr.push_back(rom_load_pkg::ioctl_addr_t'(addr));
        step_data.push_back(data);
        step_dl.push_back(cur_dl);
        step_exp.push_back(exp);
        step_name.push_back(name);
    endtask

    // Host byte, only lands in the model while the download level is high
    task automatic add_write(input int unsigned addr, input string tag);
        rom_load_pkg::byte_t d;
        random_byte(d);
        if (cur_dl) begin
            model_write(addr, d);
        end
        add_step(OP_WR, addr, d, 16'h0000, $sformatf("%s wr 0x%03h", tag, addr));
    endtask

    task automatic add_level(input logic dl, input string tag);
        cur_dl = dl;
        add_step(OP_IDLE, 0, 8'h00, 16'h0000, tag);
    endtask

    task automatic add_chr_read(input int unsigned idx, input string tag);
        add_step(OP_RD_CHR, idx, 8'h00, {8'h00, chr_model[idx]},
                 $sformatf("%s chr[0x%03h]", tag, idx));
    endtask

    task automatic add_prg_read(input int unsigned idx, input string tag);
        add_step(OP_RD_PRG, idx, 8'h00, prg_model[idx], $sformatf("%s prg[0x%03h]", tag, idx));
    endtask

    task automatic add_status_check(input string tag, input logic dl_exp, input logic done_exp);
        add_step(OP_STATUS, 0, 8'h00, {14'd0, dl_exp, done_exp}, tag);
    endtask

    task automatic build_table();
        add_status_check("after reset", 1'b0, 1'b0);

        // First download fills both ROMs
        add_level(1'b1, "dl1 rise");
        add_status_check("dl1 loading", 1'b1, 1'b0);
        for (int unsigned a = 0; a < 'hC00; a++) begin
            add_write(a, "dl1");
        end
        add_level(1'b0, "dl1 fall");
        add_status_check("dl1 done", 1'b0, 1'b1);
        for (int unsigned i = 0; i < 1024; i++) begin
            add_chr_read(i, "dl1");
        end
        for (int unsigned i = 0; i < 1024; i++) begin
            add_prg_read(i, "dl1");
        end

        // Strobes with the level low, nothing may change
        add_write(5, "nodl");
        add_write('h400, "nodl");
        add_write('h401, "nodl");
        add_write('hBFF, "nodl");
        add_level(1'b0, "nodl settle");
        add_status_check("nodl status", 1'b0, 1'b1);
        add_chr_read(5, "nodl");
        add_prg_read(0, "nodl");
        add_prg_read('h3FF, "nodl");

        // Second download, partial overwrite then window edges
        add_level(1'b1, "dl2 rise");
        add_status_check("dl2 loading", 1'b1, 1'b0);
        for (int unsigned a = 0; a < 64; a++) begin
            add_write(a, "dl2");
        end
        for (int unsigned a = 'h400; a < 'h480; a++) begin
            add_write(a, "dl2");
        end
        // Out of window bytes come last so no later write hides a stray one
        add_write('h400, "edge first");
        add_write('hBFF, "edge last");
        add_write('h3FF, "edge below");
        add_write('hC00, "edge past");
        add_level(1'b0, "dl2 fall");
        add_status_check("dl2 done", 1'b0, 1'b1);
        for (int unsigned i = 0; i < 1024; i++) begin
            add_chr_read(i, "dl2");
        end
        for (int unsigned i = 0; i < 1024; i++) begin
            add_prg_read(i, "dl2");
        end
    endtask

    // Read data is stable at the falling edge after the sampling edge
    task automatic check_pending();
        if (pending_op == OP_RD_CHR) begin
            check_byte(pending_name, pending_exp[7:0], chr_data);
        end else if (pending_op == OP_RD_PRG) begin
            check_word(pending_name, pending_exp, prg_data);
        end
        pending_op = OP_IDLE;
    endtask

    // Watchdog scaled to the table length
    initial begin
        wait (table_ready === 1'b1);
        #(CLK_PERIOD * (step_op.size() * 4 + 200));
        abort_run("Timeout: the stimulus table was not finished in time");
    end

    initial begin
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        chr_addr       = '0;
        prg_addr       = '0;
        lfsr_state     = 16'd61;
        cur_dl         = 1'b0;
        pending_op     = OP_IDLE;
        pending_exp    = '0;
        pending_name   = "";
        table_ready    = 1'b0;

        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < step_op.size(); i++) begin
            @(negedge clk);
            check_pending();
            ioctl_wr       = 1'b0;
            ioctl_download = step_dl[i];
            case (step_op[i])
                OP_WR: begin
                    ioctl_wr   = 1'b1;
                    ioctl_addr = step_addr[i];
                    ioctl_dout = step_data[i];
                end
                OP_RD_CHR: begin
                    chr_addr     = rom_load_pkg::chr_addr_t'(step_addr[i]);
                    pending_op   = OP_RD_CHR;
                    pending_exp  = step_exp[i];
                    pending_name = step_name[i];
                end
                OP_RD_PRG: begin
                    prg_addr     = rom_load_pkg::prg_addr_t'(step_addr[i]);
                    pending_op   = OP_RD_PRG;
                    pending_exp  = step_exp[i];
                    pending_name = step_name[i];
                end
                OP_STATUS: begin
                    check_flag({step_name[i], " downloading"}, step_exp[i][1], downloading);
                    check_flag({step_name[i], " dwnld_done"}, step_exp[i][0], dwnld_done);
                end
                default: begin
                end
            endcase
        end

        // Last read in the table
        @(negedge clk);
        check_pending();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== rom_load.f ====
+incdir+rtl
rtl/rom_load_pkg.sv
rtl/rpwp_ram.sv
rtl/bram_rom.sv
rtl/prog_dwnld.sv
rtl/rom_load_top.sv
verif/rom_load_tb.sv

// ==== Bender.yml ====
package:
  name: rom_load

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rom_load_pkg.sv
      - rtl/rpwp_ram.sv
      - rtl/bram_rom.sv
      - rtl/prog_dwnld.sv
      - rtl/rom_load_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/rom_load_tb.sv
